// File: design/lane_cfg_pkg.sv
/* Lane geometry and scalar types */

package lane_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NrBanks    = 4;
  localparam int unsigned NrVInsn    = 4;
  localparam int unsigned NrOpQueues = 4;
  localparam int unsigned VregWords  = 16;
  localparam int unsigned NrWriters  = 3;
  localparam int unsigned NrMasters  = NrOpQueues + NrWriters;
  localparam int unsigned BankSelW   = $clog2(NrBanks);

  // Arbiter group sizes per bank
  localparam int unsigned NrHpMasters = 4;
  localparam int unsigned NrLpMasters = 3;

  // Writer slots, counted after the operand queues
  localparam int unsigned WbAlu  = 0;
  localparam int unsigned WbMfpu = 1;
  localparam int unsigned WbLdu  = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Scalar types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;
  // Bits [1:0] pick the bank
  typedef logic [8:0]  vaddr_t;
  typedef logic [6:0]  bank_addr_t;
  typedef logic [1:0]  vid_t;
  typedef logic [7:0]  vlen_t;
  typedef logic [4:0]  vreg_t;

  typedef enum logic [1:0] {
    ew8,
    ew16,
    ew32,
    ew64
  } vew_e;

  typedef enum logic [1:0] {
    alu_a,
    alu_b,
    mask_b,
    st_a
  } opqueue_e;

endpackage

// File: design/operand_req_pkg.sv
/* Operand request and VRF payloads */

package operand_req_pkg;

  import lane_cfg_pkg::*;

  // Read request from the lane sequencer
  typedef struct packed {
    vid_t               id;
    vreg_t              vs;
    vew_e               eew;
    vlen_t              vl;
    vlen_t              vstart;
    logic [NrVInsn-1:0] hazard;
  } operand_request_t;

  // Command towards the operand queue
  typedef struct packed {
    vew_e  eew;
    vlen_t elem_count;
  } queue_cmd_t;

  // Result word from a functional unit
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } result_t;

  // One access on a VRF bank port
  typedef struct packed {
    bank_addr_t addr;
    logic       wen;
    elen_t      wdata;
    strb_t      be;
    opqueue_e   opqueue;
  } vrf_req_t;

endpackage

// File: design/wb_stream_reg.sv
/* Load result stream register */

`timescale 1ns/1ps

module wb_stream_reg import operand_req_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  result_t data_i,
  input  logic    valid_i,
  output logic    ready_o,
  output result_t data_o,
  output logic    valid_o,
  input  logic    ready_i
);

  result_t data_q;
  logic    valid_q;

  // Free slot, or the held word leaves this cycle
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  ) else $error("load word changed under back-pressure");

endmodule

// File: design/queue_requester.sv
/* Operand queue read requester */

`timescale 1ns/1ps

module queue_requester import lane_cfg_pkg::*; import operand_req_pkg::*; #(
  parameter opqueue_e QueueId = alu_a
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Lane sequencer
  input  operand_request_t   request_i,
  input  logic               request_valid_i,
  output logic               request_ready_o,
  // Operand queue
  output queue_cmd_t         cmd_o,
  output logic               cmd_valid_o,
  input  logic               queue_ready_i,
  output logic               issued_o,
  // Hazard tracking
  output vid_t               id_o,
  input  logic [NrVInsn-1:0] hazard_row_i,
  input  logic [NrVInsn-1:0] result_written_i,
  // Bank arbiters
  output logic [NrBanks-1:0] bank_req_o,
  output vrf_req_t           payload_o,
  input  logic [NrBanks-1:0] bank_gnt_i
);

  typedef enum logic {
    Idle,
    Requesting
  } state_e;

  typedef struct packed {
    vid_t               id;
    vaddr_t             addr;
    vlen_t              len;
    vew_e               eew;
    logic [NrVInsn-1:0] hazard;
  } meta_t;

  state_e state_d, state_q;
  meta_t  meta_d, meta_q;
  meta_t  meta_new;
  vlen_t  body_len;
  vlen_t  word_elems;
  logic   stall;
  logic   granted;
  logic   last_word;
  logic   accept;

  ////////////////////////////////////////////////////////////////////////////
  // Incoming request
  ////////////////////////////////////////////////////////////////////////////

  assign body_len = request_i.vl - request_i.vstart;

  // Register base plus vstart in whole words
  assign meta_new = '{
    id:     request_i.id,
    addr:   vaddr_t'(request_i.vs * VregWords)
            + vaddr_t'(request_i.vstart >> (ew64 - request_i.eew)),
    len:    (body_len == '0) ? vlen_t'(1) : body_len,
    eew:    request_i.eew,
    hazard: request_i.hazard
  };

  assign cmd_o = '{eew: request_i.eew, elem_count: meta_new.len};

  ////////////////////////////////////////////////////////////////////////////
  // Bank request
  ////////////////////////////////////////////////////////////////////////////

  // Wait on any producer that has not written this cycle
  assign stall      = |(meta_q.hazard & ~result_written_i);
  assign word_elems = vlen_t'(1) << (ew64 - meta_q.eew);

  always_comb begin
    bank_req_o = '0;
    bank_req_o[meta_q.addr[BankSelW-1:0]] = (state_q == Requesting) && queue_ready_i && !stall;
  end

  assign payload_o = '{
    addr:    bank_addr_t'(meta_q.addr >> BankSelW),
    wen:     1'b0,
    wdata:   '0,
    be:      '0,
    opqueue: QueueId
  };

  assign granted   = |bank_gnt_i;
  assign issued_o  = granted;
  assign last_word = granted && (meta_q.len <= word_elems);
  assign id_o      = meta_q.id;

  assign request_ready_o = (state_q == Idle) || last_word;
  assign accept          = request_valid_i && request_ready_o;
  // Zero-length requests are taken but muted
  assign cmd_valid_o     = accept && (request_i.vl != '0);

  always_comb begin
    state_d = state_q;
    meta_d  = meta_q;
    if (granted) begin
      meta_d.addr = meta_q.addr + 1'b1;
      meta_d.len  = last_word ? '0 : meta_q.len - word_elems;
      if (last_word) begin
        state_d = Idle;
      end
    end
    meta_d.hazard = meta_q.hazard & hazard_row_i;
    if (accept) begin
      meta_d  = meta_new;
      state_d = (request_i.vl != '0) ? Requesting : Idle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      meta_q  <= '0;
    end else begin
      state_q <= state_d;
      meta_q  <= meta_d;
    end
  end

  // Grants come back only on the bank being asked
  a_gnt_on_req: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (bank_gnt_i & ~bank_req_o) == '0
  ) else $error("grant on a bank that was not requested");

endmodule

// File: design/rr_arbiter.sv
/* Round-robin VRF arbiter */

`timescale 1ns/1ps

module rr_arbiter import operand_req_pkg::*; #(
  parameter int unsigned NumIn = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic     [NumIn-1:0] req_i,
  input  vrf_req_t [NumIn-1:0] data_i,
  output logic     [NumIn-1:0] gnt_o,
  output logic                 req_o,
  output vrf_req_t             data_o,
  input  logic                 gnt_i
);

  localparam int unsigned IdxW = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxW-1:0] ptr_q;
  logic [IdxW-1:0] winner;

  // First requester at or after the pointer
  always_comb begin
    logic [IdxW-1:0] cand;
    logic            found;
    winner = ptr_q;
    found  = 1'b0;
    for (int unsigned i = 0; i < NumIn; i++) begin
      cand = IdxW'((ptr_q + i) % NumIn);
      if (!found && req_i[cand]) begin
        winner = cand;
        found  = 1'b1;
      end
    end
  end

  assign req_o  = |req_i;
  assign data_o = data_i[winner];

  always_comb begin
    gnt_o = '0;
    gnt_o[winner] = gnt_i && req_i[winner];
  end

  // Move past the served master
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (gnt_i && req_o) begin
      ptr_q <= (winner == IdxW'(NumIn - 1)) ? '0 : winner + 1'b1;
    end
  end

  // A granted port with any request pending serves one requester
  a_gnt_match: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (|gnt_o) == (gnt_i && req_o)
  ) else $error("arbiter grant does not match its request");

endmodule

// File: design/bank_arbiter.sv
/* Two-level VRF bank arbiter */

`timescale 1ns/1ps

module bank_arbiter import lane_cfg_pkg::*; import operand_req_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic     [NrMasters-1:0] req_i,
  input  vrf_req_t [NrMasters-1:0] payload_i,
  output logic     [NrMasters-1:0] gnt_o,
  output logic                     vrf_req_o,
  output vrf_req_t                 vrf_o
);

  logic     [NrHpMasters-1:0] hp_req_in, hp_gnt;
  vrf_req_t [NrHpMasters-1:0] hp_data_in;
  logic     [NrLpMasters-1:0] lp_req_in, lp_gnt;
  vrf_req_t [NrLpMasters-1:0] lp_data_in;
  vrf_req_t                   hp_data, lp_data;
  logic                       hp_req, lp_req;

  // High group is alu_a, alu_b, ALU and MFPU
  assign hp_req_in  = {req_i[NrOpQueues+WbMfpu], req_i[NrOpQueues+WbAlu],
                       req_i[alu_b], req_i[alu_a]};
  assign hp_data_in = {payload_i[NrOpQueues+WbMfpu], payload_i[NrOpQueues+WbAlu],
                       payload_i[alu_b], payload_i[alu_a]};
  // Low group is mask_b, st_a and the load unit
  assign lp_req_in  = {req_i[NrOpQueues+WbLdu], req_i[st_a], req_i[mask_b]};
  assign lp_data_in = {payload_i[NrOpQueues+WbLdu], payload_i[st_a], payload_i[mask_b]};

  rr_arbiter #(.NumIn(NrHpMasters)) i_hp_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (hp_req_in),
    .data_i (hp_data_in),
    .gnt_o  (hp_gnt),
    .req_o  (hp_req),
    .data_o (hp_data),
    .gnt_i  (hp_req)
  );

  // Low side only wins on an idle high side
  rr_arbiter #(.NumIn(NrLpMasters)) i_lp_arb (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (lp_req_in),
    .data_i (lp_data_in),
    .gnt_o  (lp_gnt),
    .req_o  (lp_req),
    .data_o (lp_data),
    .gnt_i  (lp_req && !hp_req)
  );

  assign vrf_req_o = hp_req || lp_req;
  assign vrf_o     = hp_req ? hp_data : lp_data;

  always_comb begin
    gnt_o                     = '0;
    gnt_o[alu_a]              = hp_gnt[0];
    gnt_o[alu_b]              = hp_gnt[1];
    gnt_o[NrOpQueues+WbAlu]   = hp_gnt[2];
    gnt_o[NrOpQueues+WbMfpu]  = hp_gnt[3];
    gnt_o[mask_b]             = lp_gnt[0];
    gnt_o[st_a]               = lp_gnt[1];
    gnt_o[NrOpQueues+WbLdu]   = lp_gnt[2];
  end

  a_port_served: assert property (
    @(posedge clk_i) disable iff (!rst_ni) vrf_req_o |-> $onehot(gnt_o)
  ) else $error("bank port busy without exactly one grant");

endmodule

// File: design/writeback_ports.sv
/* Result writeback ports */

`timescale 1ns/1ps

module writeback_ports import lane_cfg_pkg::*; import operand_req_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  result_t                               alu_result_i,
  input  logic                                  alu_result_req_i,
  output logic                                  alu_result_gnt_o,
  input  result_t                               mfpu_result_i,
  input  logic                                  mfpu_result_req_i,
  output logic                                  mfpu_result_gnt_o,
  input  result_t                               ldu_result_i,
  input  logic                                  ldu_result_req_i,
  output logic                                  ldu_result_gnt_o,
  output logic                                  ldu_result_final_gnt_o,
  output logic     [NrBanks-1:0][NrWriters-1:0] wb_req_o,
  output vrf_req_t [NrWriters-1:0]              wb_payload_o,
  input  logic     [NrBanks-1:0][NrWriters-1:0] wb_gnt_i,
  output logic     [NrVInsn-1:0]                result_written_o
);

  result_t [NrWriters-1:0] res;
  logic    [NrWriters-1:0] res_req;
  logic    [NrWriters-1:0] res_gnt;
  result_t                 ldu_q;
  logic                    ldu_req;
  logic    [NrVInsn-1:0]   written_d;

  // Load unit sees the register's ready as its grant
  wb_stream_reg i_ldu_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (ldu_result_i),
    .valid_i (ldu_result_req_i),
    .ready_o (ldu_result_gnt_o),
    .data_o  (ldu_q),
    .valid_o (ldu_req),
    .ready_i (res_gnt[WbLdu])
  );

  assign res[WbAlu]      = alu_result_i;
  assign res[WbMfpu]     = mfpu_result_i;
  assign res[WbLdu]      = ldu_q;
  assign res_req[WbAlu]  = alu_result_req_i;
  assign res_req[WbMfpu] = mfpu_result_req_i;
  assign res_req[WbLdu]  = ldu_req;

  always_comb begin
    written_d = '0;
    for (int w = 0; w < NrWriters; w++) begin
      // Opqueue carries no meaning on a write
      wb_payload_o[w] = '{
        addr:    bank_addr_t'(res[w].addr >> BankSelW),
        wen:     1'b1,
        wdata:   res[w].wdata,
        be:      res[w].be,
        opqueue: alu_a
      };
      res_gnt[w] = 1'b0;
      for (int b = 0; b < NrBanks; b++) begin
        wb_req_o[b][w] = res_req[w] && (res[w].addr[BankSelW-1:0] == b);
        res_gnt[w]     = res_gnt[w] || wb_gnt_i[b][w];
      end
      written_d[res[w].id] = written_d[res[w].id] || res_gnt[w];
    end
  end

  assign alu_result_gnt_o  = res_gnt[WbAlu];
  assign mfpu_result_gnt_o = res_gnt[WbMfpu];

  // Final load grant follows the actual VRF write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ldu_result_final_gnt_o <= 1'b0;
      result_written_o       <= '0;
    end else begin
      ldu_result_final_gnt_o <= res_gnt[WbLdu];
      result_written_o       <= written_d;
    end
  end

endmodule

// File: design/operand_requester.sv
/* Lane operand request stage */

`timescale 1ns/1ps

module operand_requester import lane_cfg_pkg::*; import operand_req_pkg::*; (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic             [NrVInsn-1:0][NrVInsn-1:0] global_hazard_table_i,
  // Lane sequencer
  input  operand_request_t [NrOpQueues-1:0]        operand_request_i,
  input  logic             [NrOpQueues-1:0]        operand_request_valid_i,
  output logic             [NrOpQueues-1:0]        operand_request_ready_o,
  // Operand queues
  input  logic             [NrOpQueues-1:0]        operand_queue_ready_i,
  output logic             [NrOpQueues-1:0]        operand_issued_o,
  output queue_cmd_t       [NrOpQueues-1:0]        operand_queue_cmd_o,
  output logic             [NrOpQueues-1:0]        operand_queue_cmd_valid_o,
  // Functional-unit results
  input  result_t                                  alu_result_i,
  input  logic                                     alu_result_req_i,
  output logic                                     alu_result_gnt_o,
  input  result_t                                  mfpu_result_i,
  input  logic                                     mfpu_result_req_i,
  output logic                                     mfpu_result_gnt_o,
  input  result_t                                  ldu_result_i,
  input  logic                                     ldu_result_req_i,
  output logic                                     ldu_result_gnt_o,
  output logic                                     ldu_result_final_gnt_o,
  // VRF bank ports
  output logic             [NrBanks-1:0]           vrf_req_o,
  output vrf_req_t         [NrBanks-1:0]           vrf_o
);

  logic     [NrOpQueues-1:0][NrBanks-1:0] q_bank_req, q_bank_gnt;
  logic     [NrBanks-1:0][NrOpQueues-1:0] rd_req, rd_gnt;
  vrf_req_t [NrOpQueues-1:0]              rd_payload;
  vid_t     [NrOpQueues-1:0]              q_id;
  logic     [NrBanks-1:0][NrWriters-1:0]  wb_req, wb_gnt;
  vrf_req_t [NrWriters-1:0]               wb_payload;
  logic     [NrVInsn-1:0]                 result_written;

  for (genvar q = 0; q < NrOpQueues; q++) begin : gen_queue
    queue_requester #(.QueueId(opqueue_e'(q))) i_requester (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .request_i        (operand_request_i[q]),
      .request_valid_i  (operand_request_valid_i[q]),
      .request_ready_o  (operand_request_ready_o[q]),
      .cmd_o            (operand_queue_cmd_o[q]),
      .cmd_valid_o      (operand_queue_cmd_valid_o[q]),
      .queue_ready_i    (operand_queue_ready_i[q]),
      .issued_o         (operand_issued_o[q]),
      .id_o             (q_id[q]),
      .hazard_row_i     (global_hazard_table_i[q_id[q]]),
      .result_written_i (result_written),
      .bank_req_o       (q_bank_req[q]),
      .payload_o        (rd_payload[q]),
      .bank_gnt_i       (q_bank_gnt[q])
    );
    // Queue-major to bank-major
    for (genvar b = 0; b < NrBanks; b++) begin : gen_xpose
      assign rd_req[b][q]     = q_bank_req[q][b];
      assign q_bank_gnt[q][b] = rd_gnt[b][q];
    end
  end

  writeback_ports i_writeback (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .alu_result_i           (alu_result_i),
    .alu_result_req_i       (alu_result_req_i),
    .alu_result_gnt_o       (alu_result_gnt_o),
    .mfpu_result_i          (mfpu_result_i),
    .mfpu_result_req_i      (mfpu_result_req_i),
    .mfpu_result_gnt_o      (mfpu_result_gnt_o),
    .ldu_result_i           (ldu_result_i),
    .ldu_result_req_i       (ldu_result_req_i),
    .ldu_result_gnt_o       (ldu_result_gnt_o),
    .ldu_result_final_gnt_o (ldu_result_final_gnt_o),
    .wb_req_o               (wb_req),
    .wb_payload_o           (wb_payload),
    .wb_gnt_i               (wb_gnt),
    .result_written_o       (result_written)
  );

  // Writers sit above the queues in master order
  for (genvar b = 0; b < NrBanks; b++) begin : gen_bank
    bank_arbiter i_bank_arb (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .req_i     ({wb_req[b], rd_req[b]}),
      .payload_i ({wb_payload, rd_payload}),
      .gnt_o     ({wb_gnt[b], rd_gnt[b]}),
      .vrf_req_o (vrf_req_o[b]),
      .vrf_o     (vrf_o[b])
    );
  end

endmodule

// File: test/tb_vectors.svh
/* Operand request test cases */

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef enum logic [1:0] {
  wr_none,
  wr_alu,
  wr_ldu
} wr_kind_e;

// Random rows draw vs, eew and vstart at run time and carry no expected values
typedef struct packed {
  opqueue_e           q;
  logic               rnd;
  vid_t               id;
  vreg_t              vs;
  vew_e               eew;
  vlen_t              vl;
  vlen_t              vstart;
  logic [NrVInsn-1:0] hazard;
  logic [NrVInsn-1:0] hz_row;
  vlen_t              qr_hold;
  wr_kind_e           wr_kind;
  vid_t               wr_id;
  vlen_t              wr_start;
  vlen_t              wr_count;
  vlen_t              wr_gap;
  vlen_t              clr_cyc;
  vlen_t              exp_words;
  vaddr_t             exp_addr;
} vec_case_t;

localparam int    NrCases = 11;
localparam vlen_t Never   = 8'hff;

// Writes land in the same bank as the first read word
localparam vec_case_t Cases [NrCases] = '{
  // q     rnd   id vs eew   vl  vst  hazard   row      hold kind     wid st cnt gap clr
  //                                                                        words addr
  '{alu_a,  1'b0, 0, 3, ew64, 5,  0, 4'b0000, 4'b0000, 0, wr_none, 0, 0, 0, 1, Never, 5, 48},
  '{alu_b,  1'b0, 1, 5, ew8,  20, 8, 4'b0000, 4'b0000, 0, wr_none, 0, 0, 0, 1, Never, 2, 81},
  '{st_a,   1'b0, 2, 2, ew16, 13, 3, 4'b0000, 4'b0000, 0, wr_none, 0, 0, 0, 1, Never, 3, 32},
  // Queue held low for five cycles
  '{mask_b, 1'b0, 3, 1, ew32, 9,  1, 4'b0000, 4'b0000, 5, wr_none, 0, 0, 0, 1, Never, 4, 16},
  // ALU write beats mask_b on the same bank
  '{mask_b, 1'b0, 0, 7, ew64, 3,  0, 4'b0000, 4'b0000, 0, wr_alu,  1, 0, 1, 1, Never, 3, 112},
  '{alu_a,  1'b0, 1, 4, ew64, 4,  0, 4'b0000, 4'b0000, 0, wr_ldu,  3, 0, 1, 1, Never, 4, 64},
  // Stalled on id 2 until three writes, then released
  '{alu_b,  1'b0, 0, 6, ew64, 6,  0, 4'b0100, 4'b0100, 0, wr_alu,  2, 3, 3, 4, 20,    6, 96},
  '{st_a,   1'b0, 2, 9, ew8,  0,  0, 4'b0000, 4'b0000, 0, wr_none, 0, 0, 0, 1, Never, 0, 0},
  '{alu_a,  1'b1, 3, 0, ew8,  24, 0, 4'b0000, 4'b0000, 0, wr_none, 0, 0, 0, 1, Never, 0, 0},
  '{mask_b, 1'b1, 1, 0, ew8,  40, 0, 4'b0000, 4'b0000, 2, wr_none, 0, 0, 0, 1, Never, 0, 0},
  '{st_a,   1'b1, 2, 0, ew8,  32, 0, 4'b0000, 4'b0000, 0, wr_ldu,  0, 1, 1, 1, Never, 0, 0}
};

`endif

// File: test/tb_operand_requester.sv
/* Operand requester testbench */

`timescale 1ns/1ps

module tb_operand_requester import lane_cfg_pkg::*; import operand_req_pkg::*; ();

  `include "tb_vectors.svh"

  localparam int ResetCycles = 8;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic             [NrVInsn-1:0][NrVInsn-1:0] hz_table;
  operand_request_t [NrOpQueues-1:0]           op_req;
  logic             [NrOpQueues-1:0]           op_req_valid, op_req_ready, queue_ready;
  logic             [NrOpQueues-1:0]           issued, cmd_valid, exp_iss, exp_cmd;
  queue_cmd_t       [NrOpQueues-1:0]           cmd;
  result_t                                     alu_res, mfpu_res, ldu_res, wr_exp;
  logic             alu_req, alu_gnt, mfpu_req, mfpu_gnt, ldu_req, ldu_gnt, ldu_final;
  logic             [NrBanks-1:0]              vrf_req;
  vrf_req_t         [NrBanks-1:0]              vrf;

  // Reference model state
  integer             seed;
  int                 err_count = 0;
  opqueue_e           cur_q = alu_a;
  operand_request_t   cur_req = '0;
  vaddr_t             exp_addr = '0;
  vaddr_t             first_addr;
  int                 exp_left = 0;
  int                 words_seen, issued_seen, cmd_seen, reads_now;
  logic [NrVInsn-1:0] hz_reg = '0;
  logic [NrVInsn-1:0] written_prev = '0;
  logic [NrVInsn-1:0] written_now;
  logic               wr_exp_valid = 1'b0;
  logic               wr_exp_ldu, ldu_now, first_seen, blocked, accept;
  logic               ldu_prev = 1'b0;

  always #4 clk_i = ~clk_i;

  operand_requester UUT (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .global_hazard_table_i     (hz_table),
    .operand_request_i         (op_req),
    .operand_request_valid_i   (op_req_valid),
    .operand_request_ready_o   (op_req_ready),
    .operand_queue_ready_i     (queue_ready),
    .operand_issued_o          (issued),
    .operand_queue_cmd_o       (cmd),
    .operand_queue_cmd_valid_o (cmd_valid),
    .alu_result_i              (alu_res),
    .alu_result_req_i          (alu_req),
    .alu_result_gnt_o          (alu_gnt),
    .mfpu_result_i             (mfpu_res),
    .mfpu_result_req_i         (mfpu_req),
    .mfpu_result_gnt_o         (mfpu_gnt),
    .ldu_result_i              (ldu_res),
    .ldu_result_req_i          (ldu_req),
    .ldu_result_gnt_o          (ldu_gnt),
    .ldu_result_final_gnt_o    (ldu_final),
    .vrf_req_o                 (vrf_req),
    .vrf_o                     (vrf)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Address and length rules
  ////////////////////////////////////////////////////////////////////////////

  // One word holds 2^(3-eew) elements
  function automatic int words_for(input operand_request_t r);
    int per;
    per = 1 << (3 - int'(r.eew));
    if (r.vl == '0) begin
      return 0;
    end
    return (int'(r.vl) - int'(r.vstart) + per - 1) / per;
  endfunction

  function automatic vaddr_t start_addr(input operand_request_t r);
    return vaddr_t'(int'(r.vs) * VregWords + (int'(r.vstart) >> (3 - int'(r.eew))));
  endfunction

  function automatic int case_cycles(input vec_case_t c);
    int n;
    n = int'(c.vl) + int'(c.qr_hold) + int'(c.wr_start) + int'(c.wr_count) * int'(c.wr_gap) + 8;
    if (c.clr_cyc != Never) begin
      n += int'(c.clr_cyc);
    end
    return n;
  endfunction

  task automatic report_error(input string msg);
    err_count++;
    $display("error t=%0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_read(input int b);
    assert (exp_left > 0 && vrf[b].opqueue == cur_q && queue_ready[cur_q] && !blocked)
      else report_error($sformatf("unexpected read by queue %0d on bank %0d", vrf[b].opqueue, b));
    assert (b == int'(exp_addr[1:0]) && vrf[b].addr == bank_addr_t'(exp_addr >> 2))
      else report_error($sformatf("read bank %0d addr %0h, expected bank %0d addr %0h",
                                  b, vrf[b].addr, exp_addr[1:0], exp_addr >> 2));
    if (!first_seen) begin
      first_addr = vaddr_t'({vrf[b].addr, 2'(b)});
      first_seen = 1'b1;
    end
    exp_addr++;
    exp_left--;
    words_seen++;
    reads_now++;
  endtask

  task automatic check_write(input int b);
    assert (wr_exp_valid && b == int'(wr_exp.addr[1:0])
            && vrf[b].addr == bank_addr_t'(wr_exp.addr >> 2)
            && vrf[b].wdata == wr_exp.wdata && vrf[b].be == wr_exp.be)
      else report_error($sformatf("write on bank %0d addr %0h data %h does not match",
                                  b, vrf[b].addr, vrf[b].wdata));
    written_now[wr_exp.id] = 1'b1;
    ldu_now      = wr_exp_ldu;
    wr_exp_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      // A producer written last cycle lifts its hazard for this cycle
      blocked     = |(hz_reg & ~written_prev);
      accept      = op_req_valid[cur_q];
      written_now = '0;
      ldu_now     = 1'b0;
      reads_now   = 0;
      if (exp_left > 0 && queue_ready[cur_q] && !blocked) begin
        assert (vrf_req[exp_addr[1:0]])
          else report_error("ready and unstalled read never reached its bank");
      end
      for (int b = 0; b < NrBanks; b++) begin
        if (vrf_req[b] && vrf[b].wen) begin
          check_write(b);
        end else if (vrf_req[b]) begin
          check_read(b);
        end
      end
      exp_iss        = '0;
      exp_iss[cur_q] = (reads_now != 0);
      exp_cmd        = '0;
      exp_cmd[cur_q] = accept && (cur_req.vl != '0);
      assert (issued == exp_iss && cmd_valid == exp_cmd && ldu_final == ldu_prev)
        else report_error($sformatf("issued %b cmd_valid %b final_gnt %b, expected %b %b %b",
                                    issued, cmd_valid, ldu_final, exp_iss, exp_cmd, ldu_prev));
      // ALU grant only with an ALU write on a port, MFPU never drives
      assert (alu_gnt == ((written_now != '0) && !ldu_now) && !mfpu_gnt)
        else report_error($sformatf("alu_gnt %b mfpu_gnt %b do not match the writes seen",
                                    alu_gnt, mfpu_gnt));
      if (exp_cmd != '0) begin
        assert (cmd[cur_q].elem_count == vlen_t'(cur_req.vl - cur_req.vstart)
                && cmd[cur_q].eew == cur_req.eew)
          else report_error($sformatf("elem_count %0d", cmd[cur_q].elem_count));
        cmd_seen++;
      end
      assert (!op_req_valid[cur_q] || op_req_ready[cur_q])
        else report_error("idle requester did not take the request");
      issued_seen += int'(issued[cur_q]);
      written_prev = written_now;
      ldu_prev     = ldu_now;
      if (accept) begin
        hz_reg   = cur_req.hazard;
        exp_left = words_for(cur_req);
        exp_addr = start_addr(cur_req);
      end else begin
        hz_reg = hz_reg & hz_table[cur_req.id];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_result(input vec_case_t c, input operand_request_t r, input int n);
    result_t res;
    res.id    = c.wr_id;
    res.addr  = start_addr(r) ^ vaddr_t'(9'h100);
    res.wdata = {32'hfeed0000 | 32'(n), 32'($random(seed))};
    res.be    = (c.wr_kind == wr_ldu) ? 8'h0f : 8'hff;
    wr_exp       = res;
    wr_exp_ldu   = (c.wr_kind == wr_ldu);
    wr_exp_valid = 1'b1;
    if (c.wr_kind == wr_alu) begin
      alu_res = res;
      alu_req = 1'b1;
    end else begin
      ldu_res = res;
      ldu_req = 1'b1;
    end
    // Look after the port monitor has seen this cycle
    @(negedge clk_i);
    #1;
    if (c.wr_kind == wr_alu) begin
      assert (alu_gnt) else report_error("ALU write not granted in the cycle it was presented");
      assert (!wr_exp_valid) else report_error("ALU write missing from its bank port");
    end else begin
      assert (ldu_gnt) else report_error("load result refused with the stream register free");
      assert (wr_exp_valid)
        else report_error("load result reached the VRF in the cycle it was presented");
    end
  endtask

  task automatic run_case(input int idx);
    vec_case_t        c;
    operand_request_t r;
    int               cyc;
    int               wr_done;
    logic             done;
    c = Cases[idx];
    r = '{id: c.id, vs: c.vs, eew: c.eew, vl: c.vl, vstart: c.vstart, hazard: c.hazard};
    if (c.rnd) begin
      r.vs     = vreg_t'($random(seed));
      r.eew    = vew_e'(2'($random(seed)));
      r.vstart = vlen_t'($unsigned($random(seed)) % c.vl);
    end
    @(posedge clk_i);
    #1;
    cur_q       = c.q;
    cur_req     = r;
    words_seen  = 0;
    issued_seen = 0;
    cmd_seen    = 0;
    first_seen  = 1'b0;
    hz_table           = '0;
    hz_table[c.id]     = c.hz_row;
    op_req[c.q]        = r;
    op_req_valid[c.q]  = 1'b1;
    queue_ready        = '1;
    queue_ready[c.q]   = (c.qr_hold == '0);
    cyc     = 0;
    wr_done = 0;
    done    = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      #1;
      op_req_valid     = '0;
      alu_req          = 1'b0;
      ldu_req          = 1'b0;
      queue_ready[c.q] = (cyc >= int'(c.qr_hold));
      if (cyc == int'(c.clr_cyc)) begin
        hz_table = '0;
      end
      if (c.wr_kind != wr_none && wr_done < int'(c.wr_count)
          && cyc == int'(c.wr_start) + wr_done * int'(c.wr_gap)) begin
        send_result(c, r, wr_done);
        wr_done++;
      end
      cyc++;
      done = (exp_left == 0) && (wr_done == int'(c.wr_count)) && !wr_exp_valid
             && (cyc > int'(c.qr_hold));
    end
    assert (issued_seen == words_seen && cmd_seen == ((c.vl != '0) ? 1 : 0))
      else report_error($sformatf("case %0d: %0d issued, %0d words, %0d commands",
                                  idx, issued_seen, words_seen, cmd_seen));
    if (!c.rnd) begin
      assert (words_seen == int'(c.exp_words))
        else report_error($sformatf("case %0d: %0d words, expected %0d",
                                    idx, words_seen, c.exp_words));
      if (c.exp_words != '0) begin
        assert (first_addr == c.exp_addr)
          else report_error($sformatf("case %0d: first address %0d, expected %0d",
                                      idx, first_addr, c.exp_addr));
      end
    end
  endtask

  initial begin
    seed         = 32'hca5c;
    rst_ni       = 1'b0;
    hz_table     = '0;
    op_req       = '0;
    op_req_valid = '0;
    queue_ready  = '1;
    alu_res      = '0;
    mfpu_res     = '0;
    ldu_res      = '0;
    alu_req      = 1'b0;
    mfpu_req     = 1'b0;
    ldu_req      = 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (op_req_ready == '1 && ldu_gnt && !ldu_final && vrf_req == '0 && issued == '0
            && cmd_valid == '0 && !alu_gnt && !mfpu_gnt)
      else report_error("outputs not at their reset values");
    for (int i = 0; i < NrCases; i++) begin
      run_case(i);
    end
    repeat (4) @(posedge clk_i);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog sized from the case table
  initial begin
    int budget;
    budget = 0;
    for (int i = 0; i < NrCases; i++) begin
      budget += case_cycles(Cases[i]);
    end
    repeat (ResetCycles + 4 * budget + 100) @(posedge clk_i);
    $display("Watchdog expired before all cases finished");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

// File: list.f
+incdir+test
design/lane_cfg_pkg.sv
design/operand_req_pkg.sv
design/wb_stream_reg.sv
design/queue_requester.sv
design/rr_arbiter.sv
design/bank_arbiter.sv
design/writeback_ports.sv
design/operand_requester.sv
test/tb_operand_requester.sv
